// File: testbench/colmix_input.txt
# cmd game fields; game is 0, 1 or 2 for both games; fields are hex
# W addr byte | R addr expected byte | P lhbl lvbl prio_latch gfx1 gfx2 expected {blue,green,red}
# Overwrite of one address
W 2 0a ee
R 2 0a ee
W 2 0a 11
R 2 0a 11
# Palette, colour at index i is {byte 2i+1 bits 6..0, byte 2i}
W 2 0b 22
W 2 2a 33
W 2 2b c4
W 2 40 55
W 2 41 66
W 2 60 77
W 2 61 88
W 2 94 99
W 2 95 1a
W 2 b4 bb
W 2 b5 ac
W 2 c0 dd
W 2 c1 3e
W 2 e0 f0
W 2 e1 ff
W 2 fe 0f
W 2 ff 81
R 2 ff 81
R 2 fe 0f
R 2 2b c4
R 2 e1 ff
R 2 0a 11
# Two-layer rule
P 0 1 1 0 20 4a 1a99
P 0 1 1 0 20 5a 2cbb
P 0 1 1 0 05 4a 1a99
P 0 1 1 0 05 5a 2211
P 0 1 1 0 15 5a 4433
P 0 1 1 0 20 7f 010f
P 0 1 1 1 05 5a 2211
# Latch rule with latch low
P 1 1 1 0 20 60 3edd
P 1 1 1 0 20 70 6655
P 1 1 1 0 20 4a 1a99
P 1 1 1 0 20 5a 6655
P 1 1 1 0 30 60 3edd
P 1 1 1 0 30 70 0877
P 1 1 1 0 30 4a 1a99
P 1 1 1 0 30 5a 0877
P 1 1 1 0 05 60 3edd
P 1 1 1 0 05 70 7ff0
P 1 1 1 0 05 4a 1a99
P 1 1 1 0 05 5a 2cbb
P 1 1 1 0 15 60 3edd
P 1 1 1 0 15 70 7ff0
P 1 1 1 0 15 4a 1a99
P 1 1 1 0 15 5a 2cbb
# Latch rule with latch high
P 1 1 1 1 20 60 6655
P 1 1 1 1 20 70 6655
P 1 1 1 1 20 4a 6655
P 1 1 1 1 20 5a 6655
P 1 1 1 1 30 60 0877
P 1 1 1 1 30 70 0877
P 1 1 1 1 30 4a 1a99
P 1 1 1 1 30 5a 2cbb
P 1 1 1 1 05 60 2211
P 1 1 1 1 05 70 2211
P 1 1 1 1 05 4a 2211
P 1 1 1 1 05 5a 2211
P 1 1 1 1 15 60 4433
P 1 1 1 1 15 70 4433
P 1 1 1 1 15 4a 1a99
P 1 1 1 1 15 5a 2cbb
# Blanking, then an active pixel with the same index in both games
P 2 0 1 0 05 5a 0000
P 2 1 0 0 05 5a 0000
P 2 0 0 1 15 4a 0000
P 2 1 1 0 15 4a 1a99
R 2 95 1a

// File: files.f
src/colmix_pkg.sv
src/colmix_prio.sv
src/colmix_palette.sv
src/colmix_blank.sv
src/colmix_top.sv
testbench/colmix_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the testbench for GAME 0 and GAME 1 with Verilator
cd "$(dirname "$0")" || exit 1
status=0
for game in 0 1; do
    log="sim_game${game}.log"
    verilator --binary --assert -Wno-fatal --top-module colmix_tb -GGAME=${game} \
        --Mdir "obj_game${game}" -o colmix_sim -f files.f > "$log" 2>&1 \
        && "./obj_game${game}/colmix_sim" >> "$log" 2>&1 \
        || echo "Verification failed: build or run error for GAME ${game}" >> "$log"
    cat "$log"
    grep -q "Verification failed" "$log" && status=1
done
exit $status

// File: testbench/colmix_tb.sv
// Run from the project root so testbench/colmix_input.txt is found; one GAME per build
`timescale 1ns/1ns
`default_nettype none

module colmix_tb #(
    parameter int GAME = 0                          // Lines tagged with other games are skipped
);

    localparam int RST_TIMEOUT = 32;                // Clocks allowed until reset drops
    localparam int PXL_TIMEOUT = 8;                 // Clocks allowed between pixel enables
    localparam int DRV_DLY     = 2;                 // Input drive after the rising edge

    logic                            clk;
    logic                            rst;
    logic                            pxl_cen;
    logic                            lhbl;
    logic                            lvbl;
    wire                             lhbl_dly;
    wire                             lvbl_dly;
    logic                            pal_cs;
    logic                            cpu_rnw;
    logic                            cpu_cen;
    logic [colmix_pkg::PAL_AW-1:0]   cpu_addr;
    logic [colmix_pkg::BYTE_W-1:0]   cpu_dout;
    wire  [colmix_pkg::BYTE_W-1:0]   pal_dout;
    logic                            prio_latch;
    logic [colmix_pkg::GFX_W-1:0]    gfx1_pxl;
    logic [colmix_pkg::GFX_W-1:0]    gfx2_pxl;
    wire  [colmix_pkg::CH_W-1:0]     red;
    wire  [colmix_pkg::CH_W-1:0]     green;
    wire  [colmix_pkg::CH_W-1:0]     blue;

    int errors;
    bit hung;                                       // A wait ran out of time
    int pe_count;                                   // Pixel enables seen by the checker

    // Pixels in flight, all four queues move together
    int                           exp_due[$];
    logic [colmix_pkg::COL_W-1:0] exp_col[$];
    logic                         exp_lh[$];
    logic                         exp_lv[$];

    colmix_top #(
        .GAME       (GAME)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .lhbl       (lhbl),
        .lvbl       (lvbl),
        .lhbl_dly   (lhbl_dly),
        .lvbl_dly   (lvbl_dly),
        .pal_cs     (pal_cs),
        .cpu_rnw    (cpu_rnw),
        .cpu_cen    (cpu_cen),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .pal_dout   (pal_dout),
        .prio_latch (prio_latch),
        .gfx1_pxl   (gfx1_pxl),
        .gfx2_pxl   (gfx2_pxl),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Reset for 4 cycles
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        #DRV_DLY rst = 1'b0;
    end

    // Half-rate pixel enable, high on every second clock
    initial begin
        pxl_cen = 1'b0;
        forever begin
            @(posedge clk);
            #DRV_DLY pxl_cen = ~pxl_cen;
        end
    end

    task automatic check_byte(input string name, input logic [colmix_pkg::BYTE_W-1:0] got,
                              input logic [colmix_pkg::BYTE_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_col(input string name, input logic [colmix_pkg::COL_W-1:0] got,
                             input logic [colmix_pkg::COL_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Returns just after the drive delay that follows a pixel enable edge
    task automatic wait_pxl();
        int n;
        n = 0;
        if (hung) return;
        do begin
            @(posedge clk);
            n++;
        end while (!pxl_cen && n < PXL_TIMEOUT);    // pxl_cen stable at the edge
        if (!pxl_cen) begin
            hung = 1'b1;
            $display("Timeout: no pixel enable within %0d clocks", PXL_TIMEOUT);
            return;
        end
        pe_count++;
        #DRV_DLY;
    endtask

    // Compares every pixel whose result is due at this enable
    task automatic check_outputs();
        while (exp_due.size() > 0 && exp_due[0] <= pe_count) begin
            check_col("{blue,green,red}", {blue, green, red}, exp_col[0]);
            check_flag("lhbl_dly", lhbl_dly, exp_lh[0]);
            check_flag("lvbl_dly", lvbl_dly, exp_lv[0]);
            exp_due.delete(0);
            exp_col.delete(0);
            exp_lh.delete(0);
            exp_lv.delete(0);
        end
    endtask

    task automatic send_pixel(input logic lh, input logic lv, input logic latch,
                              input logic [colmix_pkg::GFX_W-1:0] g1,
                              input logic [colmix_pkg::GFX_W-1:0] g2,
                              input logic [colmix_pkg::COL_W-1:0] col);
        wait_pxl();
        if (hung) return;
        check_outputs();
        lhbl       = lh;
        lvbl       = lv;
        prio_latch = latch;
        gfx1_pxl   = g1;
        gfx2_pxl   = g2;
        // Sampled at the next enable, shown BLANK_DLY enables after that
        exp_due.push_back(pe_count + 1 + colmix_pkg::BLANK_DLY);
        exp_col.push_back(col);
        exp_lh.push_back(lh);
        exp_lv.push_back(lv);
    endtask

    // Empties the pipeline with blanked idle pixels
    task automatic drain_pixels();
        while (exp_due.size() > 0 && !hung) begin
            wait_pxl();
            check_outputs();
            lhbl = 1'b0;
            lvbl = 1'b0;
        end
    endtask

    task automatic cpu_write(input logic [colmix_pkg::PAL_AW-1:0] addr,
                             input logic [colmix_pkg::BYTE_W-1:0] data);
        cpu_addr = addr;
        cpu_dout = data;
        pal_cs   = 1'b1;
        cpu_rnw  = 1'b0;
        cpu_cen  = 1'b1;
        @(posedge clk);                             // Byte stored here
        #DRV_DLY;
        pal_cs   = 1'b0;
        cpu_rnw  = 1'b1;
        cpu_cen  = 1'b0;
    endtask

    task automatic cpu_read(input logic [colmix_pkg::PAL_AW-1:0] addr,
                            input logic [colmix_pkg::BYTE_W-1:0] exp);
        cpu_addr = addr;
        pal_cs   = 1'b1;
        cpu_rnw  = 1'b1;
        cpu_cen  = 1'b1;
        @(posedge clk);                             // Data one clock after the address
        #DRV_DLY;
        check_byte("pal_dout", pal_dout, exp);
        pal_cs   = 1'b0;
        cpu_cen  = 1'b0;
    endtask

    initial begin
        string       line;
        int          fd;
        int          code;
        int          nf;
        int          n;
        logic [7:0]  cmd;
        logic [31:0] game;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        logic [31:0] f5;
        errors     = 0;
        hung       = 1'b0;
        pe_count   = 0;
        lhbl       = 1'b1;                          // Active during reset to prove the flush
        lvbl       = 1'b1;
        pal_cs     = 1'b0;
        cpu_rnw    = 1'b1;
        cpu_cen    = 1'b0;
        cpu_addr   = '0;
        cpu_dout   = '0;
        prio_latch = 1'b0;
        gfx1_pxl   = 7'h05;
        gfx2_pxl   = 7'h5a;

        // Poll on the falling edge so the first enable after reset is not missed
        n = 0;
        while (rst && n < RST_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (rst) begin
            hung = 1'b1;
            $display("Timeout: reset still high after %0d clocks", RST_TIMEOUT);
        end else begin
            // Reset values hold until the first enable
            check_col("{blue,green,red} at reset", {blue, green, red}, colmix_pkg::COL_BLACK);
            check_flag("lhbl_dly at reset", lhbl_dly, 1'b0);
            check_flag("lvbl_dly at reset", lvbl_dly, 1'b0);
        end

        // Nothing valid has reached the output yet
        repeat (colmix_pkg::BLANK_DLY) begin
            wait_pxl();
            check_col("{blue,green,red} after reset", {blue, green, red}, colmix_pkg::COL_BLACK);
            check_flag("lhbl_dly after reset", lhbl_dly, 1'b0);
            check_flag("lvbl_dly after reset", lvbl_dly, 1'b0);
        end
        lhbl = 1'b0;
        lvbl = 1'b0;

        fd = $fopen("testbench/colmix_input.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open testbench/colmix_input.txt");
        end else begin
            while (!$feof(fd) && !hung) begin
                code = $fgets(line, fd);
                if (code > 0 && line.len() > 2 && line.getc(0) != "#") begin
                    cmd = line.getc(0);
                    nf  = $sscanf(line.substr(1, line.len() - 1), "%d %h %h %h %h %h %h",
                                  game, f0, f1, f2, f3, f4, f5);
                    if (game == 2 || game == GAME) begin
                        case (cmd)
                            "W": begin
                                drain_pixels();             // CPU changes hit no pixel in flight
                                cpu_write(f0[7:0], f1[7:0]);
                            end
                            "R": begin
                                drain_pixels();
                                cpu_read(f0[7:0], f1[7:0]);
                            end
                            "P": begin
                                if (nf != 7) begin
                                    errors++;
                                    $display("Pixel line has %0d fields instead of 7: %s", nf, line);
                                end else begin
                                    send_pixel(f0[0], f1[0], f2[0], f3[6:0], f4[6:0], f5[14:0]);
                                end
                            end
                            default: begin
                                errors++;
                                $display("Unknown command in data file: %s", line);
                            end
                        endcase
                    end
                end
            end
            drain_pixels();
            $fclose(fd);
        end

        $display("Errors: %0d, timeouts: %0d", errors, hung);
        if (errors == 0 && !hung) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/colmix_top.sv
// Single clock design; CPU accesses are qualified by cpu_cen and pxl_cen must pulse on every second clock
`timescale 1ns/1ns
`default_nettype none

module colmix_top #(
    parameter int GAME = 0                              // Priority rule, 0 or 1
) (
    input  wire                            clk,
    input  wire                            rst,
    // Video timing
    input  wire                            pxl_cen,
    input  wire                            lhbl,
    input  wire                            lvbl,
    output wire                            lhbl_dly,
    output wire                            lvbl_dly,
    // CPU access to the palette
    input  wire                            pal_cs,
    input  wire                            cpu_rnw,
    input  wire                            cpu_cen,
    input  wire   [colmix_pkg::PAL_AW-1:0] cpu_addr,
    input  wire   [colmix_pkg::BYTE_W-1:0] cpu_dout,
    output wire   [colmix_pkg::BYTE_W-1:0] pal_dout,
    // Layer requests
    input  wire                            prio_latch,  // Only read by GAME 1
    input  wire   [colmix_pkg::GFX_W-1:0]  gfx1_pxl,
    input  wire   [colmix_pkg::GFX_W-1:0]  gfx2_pxl,
    // Colour out
    output wire   [colmix_pkg::CH_W-1:0]   red,
    output wire   [colmix_pkg::CH_W-1:0]   green,
    output wire   [colmix_pkg::CH_W-1:0]   blue
);

    logic [colmix_pkg::IDX_W-1:0] pal_idx;             // Stage 1 to 2
    logic [colmix_pkg::COL_W-1:0] col_raw;             // Stage 2 to 3
    logic [colmix_pkg::COL_W-1:0] col_out;

    // Stage 1 layer priority
    colmix_prio #(
        .GAME       (GAME)
    ) u_prio (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .gfx1_pxl   (gfx1_pxl),
        .gfx2_pxl   (gfx2_pxl),
        .prio_latch (prio_latch),
        .pal_idx    (pal_idx)
    );

    // Stage 2 palette RAM and byte fetch
    colmix_palette u_palette (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .pal_idx    (pal_idx),
        .pal_cs     (pal_cs),
        .cpu_rnw    (cpu_rnw),
        .cpu_cen    (cpu_cen),
        .cpu_addr   (cpu_addr),
        .cpu_dout   (cpu_dout),
        .pal_dout   (pal_dout),
        .col_raw    (col_raw)
    );

    // Stage 3 blank alignment
    colmix_blank u_blank (
        .clk        (clk),
        .rst        (rst),
        .pxl_cen    (pxl_cen),
        .lhbl       (lhbl),
        .lvbl       (lvbl),
        .col_raw    (col_raw),
        .lhbl_dly   (lhbl_dly),
        .lvbl_dly   (lvbl_dly),
        .col_out    (col_out)
    );

    // Channel split
    assign red   = col_out[colmix_pkg::RED_LSB +: colmix_pkg::CH_W];
    assign green = col_out[colmix_pkg::GRN_LSB +: colmix_pkg::CH_W];
    assign blue  = col_out[colmix_pkg::BLU_LSB +: colmix_pkg::CH_W];

endmodule

`default_nettype wire

// File: src/colmix_blank.sv
// BLANK_DLY must be at least 2; flags and colour advance only on pxl_cen, which is never high twice in a row
`timescale 1ns/1ns
`default_nettype none

module colmix_blank (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           pxl_cen,
    input  wire                           lhbl,
    input  wire                           lvbl,
    input  wire   [colmix_pkg::COL_W-1:0] col_raw,
    output logic                          lhbl_dly,
    output logic                          lvbl_dly,
    output logic  [colmix_pkg::COL_W-1:0] col_out
);

    localparam int DLY = colmix_pkg::BLANK_DLY;

    // Flag history, newest in bit 0
    logic [DLY-1:0] lhbl_sr;
    logic [DLY-1:0] lvbl_sr;
    logic           show;                       // Aligned pixel is inside the active area

    // Oldest entry lines up with col_raw
    assign show = lhbl_sr[DLY-1] & lvbl_sr[DLY-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            lhbl_sr  <= '0;
            lvbl_sr  <= '0;
            lhbl_dly <= 1'b0;                   // Start blanked
            lvbl_dly <= 1'b0;
            col_out  <= colmix_pkg::COL_BLACK;
        end else if (pxl_cen) begin
            lhbl_sr  <= {lhbl_sr[DLY-2:0], lhbl};
            lvbl_sr  <= {lvbl_sr[DLY-2:0], lvbl};
            // Last step keeps flags with the registered colour
            lhbl_dly <= lhbl_sr[DLY-1];
            lvbl_dly <= lvbl_sr[DLY-1];
            col_out  <= show ? col_raw : colmix_pkg::COL_BLACK;
        end
    end

    // Whole pipeline relies on the half-rate pixel enable
    cen_rate_a: assert property (
        @(posedge clk) disable iff (rst)
        pxl_cen |=> !pxl_cen
    ) else $error("colmix_blank pixel enable high on consecutive cycles");

endmodule

`default_nettype wire

// File: src/colmix_palette.sv
// Needs pxl_cen on every second clock; video read is asynchronous, CPU read data lags one clock
`timescale 1ns/1ns
`default_nettype none

module colmix_palette (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            pxl_cen,
    input  wire   [colmix_pkg::IDX_W-1:0]  pal_idx,
    // CPU port
    input  wire                            pal_cs,
    input  wire                            cpu_rnw,
    input  wire                            cpu_cen,
    input  wire   [colmix_pkg::PAL_AW-1:0] cpu_addr,
    input  wire   [colmix_pkg::BYTE_W-1:0] cpu_dout,
    output logic  [colmix_pkg::BYTE_W-1:0] pal_dout,
    // Assembled colour
    output logic  [colmix_pkg::COL_W-1:0]  col_raw
);

    localparam int DEPTH = 2 ** colmix_pkg::PAL_AW;  // 256 bytes

    // Palette storage
    logic [colmix_pkg::BYTE_W-1:0] mem [0:DEPTH-1];

    logic                          pal_we;
    logic                          phase;            // Byte being fetched for the video side
    logic                          seen_cen;         // Set after the first pixel enable
    logic [colmix_pkg::PAL_AW-1:0] vid_addr;
    logic [colmix_pkg::BYTE_W-1:0] vid_q;
    logic [colmix_pkg::BYTE_W-1:0] lo_byte;          // Byte 0 held across phase 1

    assign pal_we = cpu_cen & pal_cs & ~cpu_rnw;

    // Video port never writes
    assign vid_addr = {pal_idx, phase};
    assign vid_q    = mem[vid_addr];

    // CPU port
    always_ff @(posedge clk) begin
        if (pal_we) begin
            mem[cpu_addr] <= cpu_dout;
        end
        pal_dout <= mem[cpu_addr];                   // Old data on a same-cycle write
    end

    // Byte phase restarts at each pixel enable
    always_ff @(posedge clk) begin
        if (rst) begin
            phase    <= 1'b0;
            seen_cen <= 1'b0;
        end else begin
            phase <= pxl_cen ? 1'b0 : ~phase;
            if (pxl_cen) begin
                seen_cen <= 1'b1;
            end
        end
    end

    // Fetch and join the two bytes
    always_ff @(posedge clk) begin
        if (!pxl_cen && !phase) begin
            lo_byte <= vid_q;                        // End of phase 0
        end
        if (pxl_cen) begin
            col_raw <= colmix_pkg::col_join(vid_q, lo_byte);  // vid_q holds byte 1 here
        end
    end

    // Enable must close a phase 1 cycle or byte 0 is lost
    phase_align_a: assert property (
        @(posedge clk) disable iff (rst)
        (pxl_cen && seen_cen) |-> phase
    ) else $error("colmix_palette pixel enable in byte phase 0");

endmodule

`default_nettype wire

// File: src/colmix_prio.sv
// GAME must be 0 or 1; inputs are sampled only on pxl_cen, index held between enables
`timescale 1ns/1ns
`default_nettype none

module colmix_prio #(
    parameter int GAME = 0                          // 0 two-layer rule, 1 latch rule
) (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          pxl_cen,
    input  wire  [colmix_pkg::GFX_W-1:0] gfx1_pxl,
    input  wire  [colmix_pkg::GFX_W-1:0] gfx2_pxl,
    input  wire                          prio_latch,
    output logic [colmix_pkg::IDX_W-1:0] pal_idx
);

    localparam int LOW_W = colmix_pkg::IDX_W - 1;   // Winner bits kept in GAME 1

    logic                         gfx1_blank;
    logic                         gfx2_blank;
    logic                         gfx_aux;          // Layer 2 opaque over a layer 1 bit 4 pixel
    logic                         gfx_other;
    logic                         gfx_sel;          // High when layer 2 wins
    logic [colmix_pkg::IDX_W-1:0] idx_mux;

    // Low nibble zero means transparent
    assign gfx1_blank = gfx1_pxl[3:0] == 4'h0;
    assign gfx2_blank = gfx2_pxl[3:0] == 4'h0;

    // Helper terms for the latch rule
    assign gfx_aux   = ~gfx2_blank & gfx1_pxl[4];
    assign gfx_other = ~((~gfx1_blank | ~gfx2_pxl[4]) & ~prio_latch);

    always_comb begin
        case (GAME)
            1: begin
                gfx_sel = ~(gfx_other & ~(gfx_aux & prio_latch));
                // Win bit on top selects the palette half
                idx_mux = {gfx_sel, gfx_sel ? gfx2_pxl[LOW_W-1:0] : gfx1_pxl[LOW_W-1:0]};
            end
            default: begin
                // Layer 2 unless layer 1 shows and layer 2 has bit 4 set
                gfx_sel = gfx1_blank | ~gfx2_pxl[4];
                idx_mux = gfx_sel ? gfx2_pxl : gfx1_pxl;  // Full 7-bit pixel
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pal_idx <= '0;
        end else if (pxl_cen) begin
            pal_idx <= idx_mux;                     // One index per pixel
        end
    end

    // Only the two known rules exist
    game_sel_a: assert property (@(posedge clk) (GAME == 0) || (GAME == 1))
        else $error("colmix_prio unsupported GAME %0d", GAME);

endmodule

`default_nettype wire

// File: src/colmix_pkg.sv
// Widths are fixed for two 7-bit layers and 128 colours of 15 bits; the byte layout depends on them
`default_nettype none

package colmix_pkg;

    // Video side widths
    localparam int GFX_W  = 7;              // Layer pixel request
    localparam int IDX_W  = 7;              // Selected palette index, 128 colours
    localparam int PAL_AW = IDX_W + 1;      // Index plus byte phase
    localparam int BYTE_W = 8;              // CPU data and RAM word

    // Colour format, blue on top then green then red
    localparam int COL_W   = 15;
    localparam int CH_W    = 5;
    localparam int RED_LSB = 0;
    localparam int GRN_LSB = CH_W;          // Straddles the two bytes
    localparam int BLU_LSB = 2 * CH_W;

    // Byte 0 at even address carries bits 7..0
    // Byte 1 at odd address carries bits 14..8, its bit 7 unused
    localparam int HI_W = COL_W - BYTE_W;   // Useful bits in byte 1

    // Pixel enables from index sample to colour register
    localparam int BLANK_DLY = 2;

    localparam logic [COL_W-1:0] COL_BLACK = '0;  // Output during blanking

    // Joins the two palette bytes of one colour
    function automatic logic [COL_W-1:0] col_join(
        input logic [BYTE_W-1:0] hi,        // Byte 1
        input logic [BYTE_W-1:0] lo         // Byte 0
    );
        return {hi[HI_W-1:0], lo};          // Top bit of byte 1 dropped
    endfunction

endpackage

`default_nettype wire
